// ==== hdl/exe_isa_pkg.sv ====
// execution unit operation encodings
// unit select, logical and branch modes, pc step for the link value
package exe_isa_pkg;

    // unit select
    typedef enum logic [1:0] {
        UNIT_ADD    = 2'd0,
        UNIT_LOGIC  = 2'd1,
        UNIT_SHIFT  = 2'd2,
        UNIT_BRANCH = 2'd3
    } unit_t;

    // logical mode, b is imm or rs2
    typedef enum logic [1:0] {
        LOGIC_XOR  = 2'd0,
        LOGIC_OR   = 2'd1,
        LOGIC_AND  = 2'd2,
        LOGIC_PASS = 2'd3
    } logic_mode_t;

    // branch mode, follows risc-v funct3 where one exists
    typedef enum logic [2:0] {
        BR_EQ   = 3'd0,
        BR_NE   = 3'd1,
        BR_JAL  = 3'd2,
        BR_JALR = 3'd3,
        BR_LT   = 3'd4,
        BR_GE   = 3'd5,
        BR_LTU  = 3'd6,
        BR_GEU  = 3'd7
    } branch_mode_t;

    // link value is pc plus one instruction
    localparam int PC_STEP = 4;

endpackage

// ==== hdl/exe_cfg_pkg.sv ====
// execution unit configuration defaults
// widths of data, pc and register index, thread count
package exe_cfg_pkg;

    // data width, any power of two from 8 up
    localparam int XLEN_DEFAULT = 32;

    // hardware threads, 2 or more
    localparam int THREADS_DEFAULT = 4;

    // fixed field widths
    localparam int PC_BITS = 32;
    localparam int RIDX_BITS = 5;

endpackage

// ==== hdl/exe_int_unit.sv ====
// integer unit: adder, logical unit and operand compare
// all results registered on stage advance
`timescale 1ns/1ps

module exe_int_unit #(
    parameter int XLEN = exe_cfg_pkg::XLEN_DEFAULT
) (
    input  logic                      clk,
    input  logic                      advance,
    input  logic [XLEN-1:0]           rs1_val,
    input  logic [XLEN-1:0]           rs2_val,
    input  logic                      imm_en,
    input  logic [XLEN-1:0]           imm_val,
    input  logic                      sub,
    input  exe_isa_pkg::logic_mode_t  logic_mode,
    output logic [XLEN-1:0]           sum,
    output logic [XLEN-1:0]           logic_val,
    output logic                      eq,
    output logic                      lt,
    output logic                      ltu
);

    logic [XLEN-1:0] opd_b;
    logic [XLEN-1:0] sum_next;
    logic [XLEN-1:0] logic_next;

    // second operand
    assign opd_b = imm_en ? imm_val : rs2_val;

    assign sum_next = sub ? (rs1_val - opd_b) : (rs1_val + opd_b);

    always_comb begin
        case (logic_mode)
            exe_isa_pkg::LOGIC_XOR: begin
                logic_next = rs1_val ^ opd_b;
            end
            exe_isa_pkg::LOGIC_OR: begin
                logic_next = rs1_val | opd_b;
            end
            exe_isa_pkg::LOGIC_AND: begin
                logic_next = rs1_val & opd_b;
            end
            default: begin
                logic_next = opd_b;
            end
        endcase
    end

    // ----------------------------------------------------------------------
    // result registers
    // ----------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (advance) begin
            sum       <= sum_next;
            logic_val <= logic_next;
            // compare always on the two registers, for branches
            eq        <= (rs1_val == rs2_val);
            lt        <= ($signed(rs1_val) < $signed(rs2_val));
            ltu       <= (rs1_val < rs2_val);
        end
    end

endmodule

// ==== hdl/exe_shifter.sv ====
// two-cycle barrel shifter
// amount decode in stage 0, shift in stage 1
`timescale 1ns/1ps

module exe_shifter #(
    parameter int XLEN = exe_cfg_pkg::XLEN_DEFAULT,
    localparam int SHAMT_BITS = $clog2(XLEN)
) (
    input  logic            clk,
    input  logic            advance,
    input  logic [XLEN-1:0] rs1_val,
    input  logic [XLEN-1:0] rs2_val,
    input  logic            imm_en,
    input  logic [XLEN-1:0] imm_val,
    input  logic            left,
    input  logic            arith,
    output logic [XLEN-1:0] shift_val
);

    logic [XLEN-1:0]       opd_b;
    logic [XLEN-1:0]       st0_opd;
    logic [SHAMT_BITS-1:0] st0_amt;
    logic                  st0_left;
    logic                  st0_arith;

    assign opd_b = imm_en ? imm_val : rs2_val;

    // stage 0, amount modulo xlen
    always_ff @(posedge clk) begin
        if (advance) begin
            st0_opd   <= rs1_val;
            st0_amt   <= opd_b[SHAMT_BITS-1:0];
            st0_left  <= left;
            st0_arith <= arith;
        end
    end

    // stage 1
    always_ff @(posedge clk) begin
        if (advance) begin
            if (st0_left) begin
                shift_val <= st0_opd << st0_amt;
            end else if (st0_arith) begin
                shift_val <= $signed(st0_opd) >>> st0_amt;
            end else begin
                shift_val <= st0_opd >> st0_amt;
            end
        end
    end

    a_amt_range: assert property (@(posedge clk) advance |=> (int'(st0_amt) < XLEN));

endmodule

// ==== hdl/exe_branch.sv ====
// branch unit: condition evaluation, target select
// taken and target registered into stage 1
`timescale 1ns/1ps

module exe_branch #(
    parameter int XLEN    = exe_cfg_pkg::XLEN_DEFAULT,
    parameter int THREADS = exe_cfg_pkg::THREADS_DEFAULT,
    localparam int PCW    = exe_cfg_pkg::PC_BITS
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       advance,
    input  logic                       live,
    input  exe_isa_pkg::branch_mode_t  mode,
    input  logic                       is_branch,
    input  logic                       eq,
    input  logic                       lt,
    input  logic                       ltu,
    input  logic [XLEN-1:0]            sum,
    input  logic [PCW-1:0]             imm_pc,
    output logic                       taken_now,
    output logic                       branch_taken,
    output logic [PCW-1:0]             branch_pc
);

    logic           cond;
    logic [PCW-1:0] jalr_pc;

    if (THREADS < 2) begin : g_threads_check
        $error("exe_branch needs at least two threads");
    end

    always_comb begin
        case (mode)
            exe_isa_pkg::BR_EQ:  cond = eq;
            exe_isa_pkg::BR_NE:  cond = !eq;
            exe_isa_pkg::BR_LT:  cond = lt;
            exe_isa_pkg::BR_GE:  cond = !lt;
            exe_isa_pkg::BR_LTU: cond = ltu;
            exe_isa_pkg::BR_GEU: cond = !ltu;
            default:             cond = 1'b1;
        endcase
    end

    // dead instructions never flip a phase
    assign taken_now = live && is_branch && cond;

    // rs1 + imm with the low bit dropped
    assign jalr_pc = PCW'(sum) & ~PCW'(1);

    always_ff @(posedge clk) begin
        if (reset) begin
            branch_taken <= 1'b0;
        end else if (advance) begin
            branch_taken <= taken_now;
        end
    end

    // only a real jalr uses the adder target
    always_ff @(posedge clk) begin
        if (advance) begin
            branch_pc <= (is_branch && (mode == exe_isa_pkg::BR_JALR)) ? jalr_pc : imm_pc;
        end
    end

    a_jalr_target: assert property (@(posedge clk) disable iff (reset)
        advance && live && is_branch && (mode == exe_isa_pkg::BR_JALR)
        |=> branch_taken && !branch_pc[0]);

endmodule

// ==== hdl/exe_phase_table.sv ====
// per-thread phase table
// judges liveness of the stage 0 instruction, flips on taken branches
`timescale 1ns/1ps

module exe_phase_table #(
    parameter int THREADS  = exe_cfg_pkg::THREADS_DEFAULT,
    localparam int ID_BITS = $clog2(THREADS)
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               advance,
    input  logic [ID_BITS-1:0] id,
    input  logic               phase,
    input  logic               valid,
    input  logic               taken,
    output logic               live
);

    logic [THREADS-1:0] table_q;

    assign live = valid && (table_q[id] == phase);

    always_ff @(posedge clk) begin
        if (reset) begin
            table_q <= '0;
        end else if (advance && live && taken) begin
            table_q[id] <= !table_q[id];
        end
    end

    a_id_range: assert property (@(posedge clk) disable iff (reset)
        valid |-> (int'(id) < THREADS));

endmodule

// ==== hdl/exe_top.sv ====
// two-stage integer execution unit for a multithreaded core
// stage control, stage registers, result select and output handshake
`timescale 1ns/1ps

module exe_top #(
    parameter int XLEN     = exe_cfg_pkg::XLEN_DEFAULT,
    parameter int THREADS  = exe_cfg_pkg::THREADS_DEFAULT,
    localparam int ID_BITS = $clog2(THREADS),
    localparam int PCW     = exe_cfg_pkg::PC_BITS,
    localparam int RIDX    = exe_cfg_pkg::RIDX_BITS
) (
    input  logic                       clk,
    input  logic                       reset,

    // input instruction
    input  logic                       in_valid,
    output logic                       in_ready,
    input  logic [ID_BITS-1:0]         in_id,
    input  logic                       in_phase,
    input  logic [PCW-1:0]             in_pc,
    input  exe_isa_pkg::unit_t         in_unit,
    input  logic                       in_rd_en,
    input  logic [RIDX-1:0]            in_rd_idx,
    input  logic [XLEN-1:0]            in_rs1_val,
    input  logic [XLEN-1:0]            in_rs2_val,
    input  logic                       in_imm_en,
    input  logic [XLEN-1:0]            in_imm_val,
    input  logic                       in_sub,
    input  exe_isa_pkg::logic_mode_t   in_logic_mode,
    input  logic                       in_shift_left,
    input  logic                       in_shift_arith,
    input  exe_isa_pkg::branch_mode_t  in_branch_mode,
    input  logic [PCW-1:0]             in_branch_pc,

    // result beat
    output logic                       out_valid,
    input  logic                       out_ready,
    output logic [ID_BITS-1:0]         out_id,
    output logic                       out_rd_en,
    output logic [RIDX-1:0]            out_rd_idx,
    output logic [XLEN-1:0]            out_rd_val,
    output logic                       out_branch_taken,
    output logic [PCW-1:0]             out_branch_pc
);

    logic                      advance;
    logic                      int_imm_en;
    logic                      int_sub;
    logic [XLEN-1:0]           sum;
    logic [XLEN-1:0]           logic_val;
    logic                      eq;
    logic                      lt;
    logic                      ltu;
    logic [XLEN-1:0]           shift_val;
    logic                      taken_now;
    logic                      st0_live;
    logic [PCW-1:0]            st0_link;
    logic [XLEN-1:0]           st0_rd_val;

    logic                      st0_valid;
    logic [ID_BITS-1:0]        st0_id;
    logic                      st0_phase;
    logic [PCW-1:0]            st0_pc;
    exe_isa_pkg::unit_t        st0_unit;
    logic                      st0_rd_en;
    logic [RIDX-1:0]           st0_rd_idx;
    exe_isa_pkg::branch_mode_t st0_branch_mode;
    logic [PCW-1:0]            st0_branch_pc;

    logic                      st1_valid;
    logic [ID_BITS-1:0]        st1_id;
    exe_isa_pkg::unit_t        st1_unit;
    logic                      st1_rd_en;
    logic [RIDX-1:0]           st1_rd_idx;
    logic [XLEN-1:0]           st1_rd_val;

    // whole pipe moves when the output slot frees up
    assign advance  = !st1_valid || out_ready;
    assign in_ready = advance;

    // branches borrow the adder for the jalr target, always rs1 + imm
    assign int_imm_en = in_imm_en || (in_unit == exe_isa_pkg::UNIT_BRANCH);
    assign int_sub    = in_sub && (in_unit != exe_isa_pkg::UNIT_BRANCH);

    // ----------------------------------------------------------------------
    // stage 0
    // ----------------------------------------------------------------------

    exe_int_unit #(.XLEN(XLEN)) u_int_unit (
        .clk        (clk),
        .advance    (advance),
        .rs1_val    (in_rs1_val),
        .rs2_val    (in_rs2_val),
        .imm_en     (int_imm_en),
        .imm_val    (in_imm_val),
        .sub        (int_sub),
        .logic_mode (in_logic_mode),
        .sum        (sum),
        .logic_val  (logic_val),
        .eq         (eq),
        .lt         (lt),
        .ltu        (ltu)
    );

    exe_shifter #(.XLEN(XLEN)) u_shifter (
        .clk       (clk),
        .advance   (advance),
        .rs1_val   (in_rs1_val),
        .rs2_val   (in_rs2_val),
        .imm_en    (in_imm_en),
        .imm_val   (in_imm_val),
        .left      (in_shift_left),
        .arith     (in_shift_arith),
        .shift_val (shift_val)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            st0_valid <= 1'b0;
        end else if (advance) begin
            st0_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            st0_id          <= in_id;
            st0_phase       <= in_phase;
            st0_pc          <= in_pc;
            st0_unit        <= in_unit;
            st0_rd_en       <= in_rd_en;
            st0_rd_idx      <= in_rd_idx;
            st0_branch_mode <= in_branch_mode;
            st0_branch_pc   <= in_branch_pc;
        end
    end

    exe_phase_table #(.THREADS(THREADS)) u_phase_table (
        .clk     (clk),
        .reset   (reset),
        .advance (advance),
        .id      (st0_id),
        .phase   (st0_phase),
        .valid   (st0_valid),
        .taken   (taken_now),
        .live    (st0_live)
    );

    exe_branch #(.XLEN(XLEN), .THREADS(THREADS)) u_branch (
        .clk          (clk),
        .reset        (reset),
        .advance      (advance),
        .live         (st0_live),
        .mode         (st0_branch_mode),
        .is_branch    (st0_unit == exe_isa_pkg::UNIT_BRANCH),
        .eq           (eq),
        .lt           (lt),
        .ltu          (ltu),
        .sum          (sum),
        .imm_pc       (st0_branch_pc),
        .taken_now    (taken_now),
        .branch_taken (out_branch_taken),
        .branch_pc    (out_branch_pc)
    );

    assign st0_link = st0_pc + PCW'(exe_isa_pkg::PC_STEP);

    // shift result arrives a cycle later and is picked in stage 1
    always_comb begin
        case (st0_unit)
            exe_isa_pkg::UNIT_ADD:    st0_rd_val = sum;
            exe_isa_pkg::UNIT_LOGIC:  st0_rd_val = logic_val;
            exe_isa_pkg::UNIT_BRANCH: st0_rd_val = XLEN'(st0_link);
            default:                  st0_rd_val = '0;
        endcase
    end

    // ----------------------------------------------------------------------
    // stage 1
    // ----------------------------------------------------------------------

    always_ff @(posedge clk) begin
        if (reset) begin
            st1_valid <= 1'b0;
        end else if (advance) begin
            // dead instructions turn into bubbles
            st1_valid <= st0_live;
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            st1_id     <= st0_id;
            st1_unit   <= st0_unit;
            st1_rd_en  <= st0_rd_en;
            st1_rd_idx <= st0_rd_idx;
            st1_rd_val <= st0_rd_val;
        end
    end

    assign out_valid  = st1_valid;
    assign out_id     = st1_id;
    assign out_rd_en  = st1_rd_en;
    assign out_rd_idx = st1_rd_idx;
    assign out_rd_val = (st1_unit == exe_isa_pkg::UNIT_SHIFT) ? shift_val : st1_rd_val;

    a_stall_stable: assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready
        |=> out_valid && $stable({out_id, out_rd_en, out_rd_idx, out_rd_val,
                                  out_branch_taken, out_branch_pc}));

endmodule

// ==== verif/exe_tb_clk.sv ====
// testbench clock source, free running from time zero
`timescale 1ns/1ps

module exe_tb_clk #(
    parameter int PERIOD_NS = 20
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2) clk = ~clk;
        end
    end

endmodule

// ==== verif/exe_tb.sv ====
// testbench for the two-stage execution unit
// reference model with phase table, checks by concurrent assertions
`timescale 1ns/1ps

module exe_tb;

    localparam int XLEN      = 32;
    localparam int THREADS   = 4;
    localparam int ID_BITS   = $clog2(THREADS);
    localparam int NUM_INSTR = 520;
    localparam int N_RAND    = 200;

    typedef struct packed {
        logic [ID_BITS-1:0] id;
        logic               rd_en;
        logic [4:0]         rd_idx;
        logic [XLEN-1:0]    rd_val;
        logic               taken;
        logic [31:0]        bpc;
        logic               lat_chk;
        logic [31:0]        acc_cyc;
    } beat_t;

    logic                      clk;
    logic                      reset;
    logic                      in_valid;
    logic                      in_ready;
    logic [ID_BITS-1:0]        in_id;
    logic                      in_phase;
    logic [31:0]               in_pc;
    exe_isa_pkg::unit_t        in_unit;
    logic                      in_rd_en;
    logic [4:0]                in_rd_idx;
    logic [XLEN-1:0]           in_rs1_val;
    logic [XLEN-1:0]           in_rs2_val;
    logic                      in_imm_en;
    logic [XLEN-1:0]           in_imm_val;
    logic                      in_sub;
    exe_isa_pkg::logic_mode_t  in_logic_mode;
    logic                      in_shift_left;
    logic                      in_shift_arith;
    exe_isa_pkg::branch_mode_t in_branch_mode;
    logic [31:0]               in_branch_pc;
    logic                      out_valid;
    logic                      out_ready;
    logic [ID_BITS-1:0]        out_id;
    logic                      out_rd_en;
    logic [4:0]                out_rd_idx;
    logic [XLEN-1:0]           out_rd_val;
    logic                      out_branch_taken;
    logic [31:0]               out_branch_pc;

    beat_t              exp_q[$];
    beat_t              head;
    logic               head_valid;
    logic [THREADS-1:0] ptab;
    logic               last_accept;
    logic               rand_ready;
    logic               lat_mode;
    logic [31:0]        cyc;
    logic [31:0]        rng;
    logic [31:0]        rng_rdy;
    int                 errors;
    int                 beats;
    int                 sent;
    logic               beat_fire;

    assign beat_fire = out_valid && out_ready;

    exe_tb_clk #(.PERIOD_NS(20)) u_clk (.clk(clk));

    exe_top #(.XLEN(XLEN), .THREADS(THREADS)) exe_top_i (
        .clk              (clk),
        .reset            (reset),
        .in_valid         (in_valid),
        .in_ready         (in_ready),
        .in_id            (in_id),
        .in_phase         (in_phase),
        .in_pc            (in_pc),
        .in_unit          (in_unit),
        .in_rd_en         (in_rd_en),
        .in_rd_idx        (in_rd_idx),
        .in_rs1_val       (in_rs1_val),
        .in_rs2_val       (in_rs2_val),
        .in_imm_en        (in_imm_en),
        .in_imm_val       (in_imm_val),
        .in_sub           (in_sub),
        .in_logic_mode    (in_logic_mode),
        .in_shift_left    (in_shift_left),
        .in_shift_arith   (in_shift_arith),
        .in_branch_mode   (in_branch_mode),
        .in_branch_pc     (in_branch_pc),
        .out_valid        (out_valid),
        .out_ready        (out_ready),
        .out_id           (out_id),
        .out_rd_en        (out_rd_en),
        .out_rd_idx       (out_rd_idx),
        .out_rd_val       (out_rd_val),
        .out_branch_taken (out_branch_taken),
        .out_branch_pc    (out_branch_pc)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // ----------------------------------------------------------------------
    // reference model, runs on every accepted instruction
    // ----------------------------------------------------------------------

    task automatic model_accept();
        beat_t           b;
        logic [XLEN-1:0] opd_b;
        int              amt;
        logic            cond;
        opd_b = in_imm_en ? in_imm_val : in_rs2_val;
        amt   = int'(opd_b % XLEN);
        cond  = 1'b0;
        b.rd_val = '0;
        case (in_unit)
            exe_isa_pkg::UNIT_ADD: begin
                b.rd_val = in_sub ? in_rs1_val - opd_b : in_rs1_val + opd_b;
            end
            exe_isa_pkg::UNIT_LOGIC: begin
                case (in_logic_mode)
                    exe_isa_pkg::LOGIC_XOR: b.rd_val = in_rs1_val ^ opd_b;
                    exe_isa_pkg::LOGIC_OR:  b.rd_val = in_rs1_val | opd_b;
                    exe_isa_pkg::LOGIC_AND: b.rd_val = in_rs1_val & opd_b;
                    default:                b.rd_val = opd_b;
                endcase
            end
            exe_isa_pkg::UNIT_SHIFT: begin
                if (in_shift_left) begin
                    b.rd_val = in_rs1_val << amt;
                end else if (in_shift_arith) begin
                    b.rd_val = $unsigned($signed(in_rs1_val) >>> amt);
                end else begin
                    b.rd_val = in_rs1_val >> amt;
                end
            end
            default: begin
                b.rd_val = in_pc + 32'(exe_isa_pkg::PC_STEP);
                case (in_branch_mode)
                    exe_isa_pkg::BR_EQ:  cond = (in_rs1_val == in_rs2_val);
                    exe_isa_pkg::BR_NE:  cond = (in_rs1_val != in_rs2_val);
                    exe_isa_pkg::BR_LT:  cond = ($signed(in_rs1_val) < $signed(in_rs2_val));
                    exe_isa_pkg::BR_GE:  cond = ($signed(in_rs1_val) >= $signed(in_rs2_val));
                    exe_isa_pkg::BR_LTU: cond = (in_rs1_val < in_rs2_val);
                    exe_isa_pkg::BR_GEU: cond = (in_rs1_val >= in_rs2_val);
                    default:             cond = 1'b1;
                endcase
            end
        endcase
        b.id      = in_id;
        b.rd_en   = in_rd_en;
        b.rd_idx  = in_rd_idx;
        b.taken   = cond;
        b.bpc     = (in_unit == exe_isa_pkg::UNIT_BRANCH &&
                     in_branch_mode == exe_isa_pkg::BR_JALR) ?
                    ((in_rs1_val + in_imm_val) & ~32'd1) : in_branch_pc;
        b.lat_chk = lat_mode;
        b.acc_cyc = cyc;
        // stale phase means the instruction is dropped
        if (in_phase == ptab[in_id]) begin
            exp_q.push_back(b);
            if (cond) begin
                ptab[in_id] = !ptab[in_id];
            end
        end
    endtask

    always @(posedge clk) begin
        if (reset) begin
            ptab        = '0;
            last_accept = 1'b0;
            exp_q.delete();
        end else begin
            if (beat_fire && exp_q.size() > 0) begin
                void'(exp_q.pop_front());
                beats++;
            end
            last_accept = in_valid && in_ready;
            if (last_accept) begin
                model_accept();
            end
        end
        head_valid = (exp_q.size() > 0);
        head       = head_valid ? exp_q[0] : '0;
        cyc        = cyc + 1;
    end

    // ----------------------------------------------------------------------
    // checks
    // ----------------------------------------------------------------------

    a_reset_state: assert property (@(posedge clk) $fell(reset) |->
        !out_valid && !out_branch_taken && in_ready)
        else begin
            errors++;
            $display("reset left the outputs in a wrong state at %0t", $time);
        end

    a_no_extra: assert property (@(posedge clk) disable iff (reset) beat_fire |-> head_valid)
        else begin
            errors++;
            $display("unexpected output beat at %0t", $time);
        end

    a_id: assert property (@(posedge clk) disable iff (reset)
        beat_fire && head_valid |-> out_id == head.id)
        else begin
            errors++;
            $display("ERROR %0t out_id expected %h actual %h",
                     $time, $sampled(head.id), $sampled(out_id));
        end

    a_rd_en: assert property (@(posedge clk) disable iff (reset)
        beat_fire && head_valid |-> out_rd_en == head.rd_en)
        else begin
            errors++;
            $display("ERROR %0t out_rd_en expected %h actual %h",
                     $time, $sampled(head.rd_en), $sampled(out_rd_en));
        end

    a_rd_idx: assert property (@(posedge clk) disable iff (reset)
        beat_fire && head_valid |-> out_rd_idx == head.rd_idx)
        else begin
            errors++;
            $display("ERROR %0t out_rd_idx expected %h actual %h",
                     $time, $sampled(head.rd_idx), $sampled(out_rd_idx));
        end

    a_rd_val: assert property (@(posedge clk) disable iff (reset)
        beat_fire && head_valid |-> out_rd_val == head.rd_val)
        else begin
            errors++;
            $display("ERROR %0t out_rd_val expected %h actual %h",
                     $time, $sampled(head.rd_val), $sampled(out_rd_val));
        end

    a_taken: assert property (@(posedge clk) disable iff (reset)
        beat_fire && head_valid |-> out_branch_taken == head.taken)
        else begin
            errors++;
            $display("ERROR %0t out_branch_taken expected %h actual %h",
                     $time, $sampled(head.taken), $sampled(out_branch_taken));
        end

    a_branch_pc: assert property (@(posedge clk) disable iff (reset)
        beat_fire && head_valid |-> out_branch_pc == head.bpc)
        else begin
            errors++;
            $display("ERROR %0t out_branch_pc expected %h actual %h",
                     $time, $sampled(head.bpc), $sampled(out_branch_pc));
        end

    // two edges from acceptance to transfer
    a_latency: assert property (@(posedge clk) disable iff (reset)
        beat_fire && head_valid && head.lat_chk |-> cyc - head.acc_cyc == 32'd2)
        else begin
            errors++;
            $display("ERROR %0t latency expected %0d actual %0d",
                     $time, 2, $sampled(cyc) - $sampled(head.acc_cyc));
        end

    a_stall: assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_ready |=> out_valid && $stable({out_id, out_rd_en,
        out_rd_idx, out_rd_val, out_branch_taken, out_branch_pc}))
        else begin
            errors++;
            $display("output changed during a stall at %0t", $time);
        end

    // ----------------------------------------------------------------------
    // stimulus
    // ----------------------------------------------------------------------

    always @(negedge clk) begin
        rng_rdy   <= xorshift(rng_rdy);
        out_ready <= rand_ready ? rng_rdy[3] : 1'b1;
    end

    task automatic issue();
        in_valid = 1'b1;
        do begin
            @(negedge clk);
        end while (!last_accept);
        in_valid = 1'b0;
        sent++;
    endtask

    task automatic set_base(input int id, input exe_isa_pkg::unit_t unit);
        rng            = xorshift(rng);
        in_id          = ID_BITS'(id);
        in_phase       = ptab[id];
        in_unit        = unit;
        in_pc          = {rng[31:2], 2'b00};
        in_rd_en       = rng[7];
        in_rd_idx      = rng[12:8];
        in_imm_en      = 1'b0;
        in_sub         = 1'b0;
        in_branch_pc   = {rng[29:0], 2'b00} ^ 32'h0000_1000;
        in_imm_val     = '0;
    endtask

    task automatic drain();
        while (exp_q.size() > 0 || out_valid) begin
            @(negedge clk);
        end
    endtask

    task automatic random_instr();
        rng = xorshift(rng);
        set_base(int'(rng[1:0]), exe_isa_pkg::unit_t'(rng[3:2]));
        if (rng[6:4] == 3'd0) begin
            in_phase = !in_phase;
        end
        rng            = xorshift(rng);
        in_rs1_val     = rng;
        rng            = xorshift(rng);
        in_rs2_val     = (rng[1:0] == 2'd0) ? in_rs1_val : rng;
        in_imm_en      = rng[5];
        in_sub         = rng[6];
        in_logic_mode  = exe_isa_pkg::logic_mode_t'(rng[8:7]);
        in_shift_left  = rng[9];
        in_shift_arith = rng[10];
        in_branch_mode = exe_isa_pkg::branch_mode_t'(rng[13:11]);
        rng            = xorshift(rng);
        in_imm_val     = rng;
        issue();
    endtask

    initial begin
        reset = 1'b1;
        in_valid = 1'b0;
        in_id = '0;
        in_phase = 1'b0;
        in_pc = '0;
        in_unit = exe_isa_pkg::UNIT_ADD;
        in_rd_en = 1'b0;
        in_rd_idx = '0;
        in_rs1_val = '0;
        in_rs2_val = '0;
        in_imm_en = 1'b0;
        in_imm_val = '0;
        in_sub = 1'b0;
        in_logic_mode = exe_isa_pkg::LOGIC_XOR;
        in_shift_left = 1'b0;
        in_shift_arith = 1'b0;
        in_branch_mode = exe_isa_pkg::BR_EQ;
        in_branch_pc = '0;
        out_ready = 1'b1;
        rand_ready = 1'b0;
        lat_mode = 1'b1;
        cyc = '0;
        rng = 32'h29cb;
        rng_rdy = 32'h29cb ^ 32'h5a5a_0000;
        errors = 0;
        beats = 0;
        sent = 0;
        repeat (10) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // add and subtract
        for (int i = 0; i < 8; i++) begin
            set_base(i % THREADS, exe_isa_pkg::UNIT_ADD);
            in_rs1_val = (i < 4) ? 32'h7fff_fff0 : 32'h0000_0005;
            in_rs2_val = (i < 4) ? 32'h0000_0020 : 32'h0000_0009;
            in_imm_val = 32'hffff_fffe;
            in_imm_en  = i[0];
            in_sub     = i[1];
            issue();
        end

        // logical modes
        for (int i = 0; i < 8; i++) begin
            set_base(i % THREADS, exe_isa_pkg::UNIT_LOGIC);
            in_rs1_val    = 32'hf0f0_33cc;
            in_rs2_val    = 32'h0ff0_5a5a;
            in_imm_val    = 32'h1234_8001;
            in_imm_en     = i[2];
            in_logic_mode = exe_isa_pkg::logic_mode_t'(i[1:0]);
            issue();
        end

        // shifts, amounts above xlen wrap
        for (int i = 0; i < 12; i++) begin
            set_base(i % THREADS, exe_isa_pkg::UNIT_SHIFT);
            in_rs1_val     = 32'h8421_00f3;
            in_rs2_val     = (i % 4 == 0) ? 32'd0 : 32'd31;
            in_imm_val     = (i % 4 == 2) ? 32'd33 : 32'd63;
            in_imm_en      = (i % 4 >= 2);
            in_shift_left  = (i / 4 == 0);
            in_shift_arith = (i / 4 == 2);
            issue();
        end

        // every branch mode on equal, signed-less and unsigned-less operands
        for (int m = 0; m < 8; m++) begin
            for (int k = 0; k < 3; k++) begin
                set_base(3, exe_isa_pkg::UNIT_BRANCH);
                in_branch_mode = exe_isa_pkg::branch_mode_t'(m);
                in_rs1_val     = (k == 0) ? 32'h55 : ((k == 1) ? 32'hffff_ff00 : 32'h10);
                in_rs2_val     = (k == 0) ? 32'h55 : 32'h0000_0020;
                in_imm_val     = 32'h0000_0103;
                issue();
            end
        end

        // taken branch kills same-thread instructions with the old phase
        begin
            logic old_phase;
            old_phase = ptab[1];
            set_base(1, exe_isa_pkg::UNIT_BRANCH);
            in_branch_mode = exe_isa_pkg::BR_JAL;
            issue();
            for (int i = 0; i < 3; i++) begin
                set_base(1, exe_isa_pkg::UNIT_ADD);
                in_phase   = old_phase;
                in_rs1_val = 32'(i);
                issue();
                set_base(2, exe_isa_pkg::UNIT_ADD);
                in_rs1_val = 32'(100 + i);
                issue();
            end
            set_base(1, exe_isa_pkg::UNIT_ADD);
            in_phase   = !old_phase;
            in_rs1_val = 32'h77;
            issue();
        end

        // random traffic with back-pressure
        drain();
        lat_mode   = 1'b0;
        rand_ready = 1'b1;
        for (int i = 0; i < N_RAND; i++) begin
            random_instr();
        end
        rand_ready = 1'b0;
        drain();
        lat_mode = 1'b1;
        for (int i = 0; i < N_RAND; i++) begin
            random_instr();
        end
        drain();
        repeat (4) @(negedge clk);

        if (exp_q.size() != 0) begin
            errors++;
            $display("%0d expected beats never appeared", exp_q.size());
        end
        $display("sent %0d instructions, %0d beats, %0d errors", sent, beats, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    // watchdog, about 20 cycles per instruction plus reset and drain margin
    initial begin
        repeat (NUM_INSTR * 20 + 1000) @(posedge clk);
        $display("timeout after %0d instructions, the run did not finish", sent);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

// ==== vlog.f ====
hdl/exe_isa_pkg.sv
hdl/exe_cfg_pkg.sv
hdl/exe_int_unit.sv
hdl/exe_shifter.sv
hdl/exe_branch.sv
hdl/exe_phase_table.sv
hdl/exe_top.sv
verif/exe_tb_clk.sv
verif/exe_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= exe_tb
DUT_TOP   ?= exe_top
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "STATUS: PASS" $(LOG) || (echo "no result in $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)
	$(VERILATOR) $(LINTFLAGS) hdl/exe_isa_pkg.sv hdl/exe_cfg_pkg.sv hdl/exe_int_unit.sv \
		hdl/exe_shifter.sv hdl/exe_branch.sv hdl/exe_phase_table.sv hdl/exe_top.sv \
		--top-module $(DUT_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
